//--- fill_pkg.sv
// Shared widths, sequencer state and word source enums, header and beat structs
package fill_pkg;

	// Width of transmit, header and memory words
	localparam int data_w = 32;

	// Words in one fill header
	localparam int hdr_words = 5;

	// Sequencer states, in frame order
	typedef enum logic [3:0] {
		IDLE,
		FETCH_HDR,
		WAIT_CSN,
		SEND_CSN,
		WAIT_CC,
		SEND_CC,
		WAIT_HDR_WORD,
		SEND_HDR_WORD,
		STREAM,
		WAIT_CHECKSUM,
		SEND_CHECKSUM,
		DONE
	} fill_state_e;

	// Transmit word source for non-data beats
	typedef enum logic [2:0] {
		SRC_CSN,
		SRC_CC,
		SRC_INV_CC,
		SRC_HEADER,
		SRC_CHECKSUM
	} word_src_e;

	// Fill header in FIFO order, trig_num popped first
	typedef struct packed {
		logic [data_w-1:0] trig_num;
		logic [data_w-1:0] buf_size;
		logic [data_w-1:0] chan_num;
		logic [data_w-1:0] post_trig;
		logic [data_w-1:0] start_addr;
	} fill_header_t;

	// One non-data beat from the sequencer
	// word only matters for SRC_HEADER
	typedef struct packed {
		logic              valid;
		logic              last;
		word_src_e         src;
		logic [data_w-1:0] word;
	} tx_beat_t;

endpackage

//--- fill_header_reader.sv
// Header reader that pops and latches five FWFT header words and flags an empty FIFO
`timescale 1ns/1ps

module fill_header_reader (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        fetch,
	input  logic [fill_pkg::data_w-1:0] hdr_fifo_dout,
	input  logic                        hdr_fifo_empty,
	output logic                        hdr_fifo_rd_en,
	output fill_pkg::fill_header_t      hdr,
	output logic                        hdr_ready,
	output logic                        hdr_error
);

	localparam int idx_w = $clog2(fill_pkg::hdr_words);

	logic             fetching;
	logic [idx_w-1:0] word_idx;

	// FWFT: the word shown is used and popped in the same cycle
	assign hdr_fifo_rd_en = fetching && !hdr_fifo_empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetching  <= 1'b0;
			word_idx  <= '0;
			hdr_ready <= 1'b0;
			hdr_error <= 1'b0;
		end else begin
			// Both answers are single-cycle pulses
			hdr_ready <= 1'b0;
			hdr_error <= 1'b0;
			if (fetch) begin
				fetching <= 1'b1;
				word_idx <= '0;
			end else if (fetching) begin
				if (hdr_fifo_empty) begin
					// Header short or missing, abandon the fetch
					fetching  <= 1'b0;
					hdr_error <= 1'b1;
				end else if (word_idx == idx_w'(fill_pkg::hdr_words - 1)) begin
					fetching  <= 1'b0;
					hdr_ready <= 1'b1;
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// Each popped word lands in its own field
	always_ff @(posedge clk) begin
		if (hdr_fifo_rd_en) begin
			case (word_idx)
				idx_w'(0): hdr.trig_num   <= hdr_fifo_dout;
				idx_w'(1): hdr.buf_size   <= hdr_fifo_dout;
				idx_w'(2): hdr.chan_num   <= hdr_fifo_dout;
				idx_w'(3): hdr.post_trig  <= hdr_fifo_dout;
				default:   hdr.start_addr <= hdr_fifo_dout;
			endcase
		end
	end

	// A new fetch never cuts into one still waiting for its answer
	a_one_answer: assert property (@(posedge clk) disable iff (!arst_n)
		fetch |-> !fetching);

endmodule

//--- fill_sequencer.sv
// Frame-order FSM with tready waits, header word stepping, stream start, done and busy
`timescale 1ns/1ps

module fill_sequencer #(
	parameter int addr_w = 12
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   run,
	input  logic                   tx_tready,
	input  fill_pkg::fill_header_t hdr,
	input  logic                   hdr_ready,
	input  logic                   hdr_error,
	input  logic                   stream_done,
	output logic                   fetch,
	output fill_pkg::tx_beat_t     beat,
	output logic                   stream_start,
	output logic [addr_w-1:0]      stream_addr,
	output logic [addr_w-1:0]      stream_count,
	output logic                   busy,
	output logic                   done
);

	fill_pkg::fill_state_e state, state_nxt;
	logic                  err;
	logic [1:0]            hdr_idx;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= fill_pkg::IDLE;
			err     <= 1'b0;
			hdr_idx <= 2'd0;
		end else if (!run) begin
			// Dispatcher dropped run, abandon the frame
			state   <= fill_pkg::IDLE;
			err     <= 1'b0;
			hdr_idx <= 2'd0;
		end else begin
			state <= state_nxt;
			if (state == fill_pkg::IDLE)
				err <= 1'b0;
			else if (state == fill_pkg::FETCH_HDR && hdr_error)
				err <= 1'b1;
			if (state == fill_pkg::SEND_CC)
				hdr_idx <= 2'd0;
			else if (state == fill_pkg::SEND_HDR_WORD)
				hdr_idx <= hdr_idx + 2'd1;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			fill_pkg::IDLE:          state_nxt = fill_pkg::FETCH_HDR;
			// An empty FIFO still answers with CSN and inverted CC
			fill_pkg::FETCH_HDR:     if (hdr_ready || hdr_error) state_nxt = fill_pkg::WAIT_CSN;
			fill_pkg::WAIT_CSN:      if (tx_tready) state_nxt = fill_pkg::SEND_CSN;
			fill_pkg::SEND_CSN:      state_nxt = fill_pkg::WAIT_CC;
			fill_pkg::WAIT_CC:       if (tx_tready) state_nxt = fill_pkg::SEND_CC;
			fill_pkg::SEND_CC:       state_nxt = err ? fill_pkg::DONE : fill_pkg::WAIT_HDR_WORD;
			fill_pkg::WAIT_HDR_WORD: if (tx_tready) state_nxt = fill_pkg::SEND_HDR_WORD;
			fill_pkg::SEND_HDR_WORD:
				state_nxt = (hdr_idx == 2'd3) ? fill_pkg::STREAM : fill_pkg::WAIT_HDR_WORD;
			// tready is not looked at while data streams
			fill_pkg::STREAM:        if (stream_done) state_nxt = fill_pkg::WAIT_CHECKSUM;
			fill_pkg::WAIT_CHECKSUM: if (tx_tready) state_nxt = fill_pkg::SEND_CHECKSUM;
			fill_pkg::SEND_CHECKSUM: state_nxt = fill_pkg::DONE;
			default:                 state_nxt = fill_pkg::IDLE;
		endcase
	end

	// One beat per SEND state, the assembler adds the register stage
	always_comb begin
		beat     = '0;
		beat.src = fill_pkg::SRC_CSN;
		if (run) begin
			case (state)
				fill_pkg::SEND_CSN: beat.valid = 1'b1;
				fill_pkg::SEND_CC: begin
					beat.valid = 1'b1;
					beat.last  = err;
					beat.src   = err ? fill_pkg::SRC_INV_CC : fill_pkg::SRC_CC;
				end
				fill_pkg::SEND_HDR_WORD: begin
					beat.valid = 1'b1;
					beat.src   = fill_pkg::SRC_HEADER;
					case (hdr_idx)
						2'd0:    beat.word = hdr.trig_num;
						2'd1:    beat.word = hdr.buf_size;
						2'd2:    beat.word = hdr.chan_num;
						default: beat.word = hdr.post_trig;
					endcase
				end
				fill_pkg::SEND_CHECKSUM: begin
					beat.valid = 1'b1;
					beat.last  = 1'b1;
					beat.src   = fill_pkg::SRC_CHECKSUM;
				end
				default: ;
			endcase
		end
	end

	assign fetch        = run && state == fill_pkg::IDLE;
	// Start the streamer as the post-trigger word goes out
	assign stream_start = run && state == fill_pkg::SEND_HDR_WORD && hdr_idx == 2'd3;
	assign stream_addr  = hdr.start_addr[addr_w-1:0];
	assign stream_count = hdr.buf_size[addr_w-1:0];
	assign busy         = run && state != fill_pkg::IDLE;
	assign done         = run && state == fill_pkg::DONE;

	// A beat goes out only in the cycle after its WAIT state saw tready
	a_beat_after_ready: assert property (@(posedge clk) disable iff (!arst_n)
		beat.valid |-> $past(tx_tready) && $past(state) inside {fill_pkg::WAIT_CSN,
			fill_pkg::WAIT_CC, fill_pkg::WAIT_HDR_WORD, fill_pkg::WAIT_CHECKSUM});

endmodule

//--- fill_mem_streamer.sv
// Memory streamer with address and word counters and the two-cycle read-valid pipeline
`timescale 1ns/1ps

module fill_mem_streamer #(
	parameter int addr_w = 12
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              stream_start,
	input  logic [addr_w-1:0] stream_addr,
	input  logic [addr_w-1:0] stream_count,
	output logic [addr_w-1:0] mem_addr,
	output logic              mem_valid,
	output logic              stream_done
);

	logic [addr_w-1:0] remain;
	logic              armed;
	logic              issue;
	logic              rd_v1;
	logic              rd_v2;

	// One read per cycle until the count runs out
	assign issue = armed && remain != '0;

	// Done once all reads have left the pipeline
	// zero count finishes the cycle after start
	assign stream_done = armed && remain == '0 && !rd_v1 && !rd_v2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_addr <= '0;
			remain   <= '0;
			armed    <= 1'b0;
			rd_v1    <= 1'b0;
			rd_v2    <= 1'b0;
		end else begin
			if (stream_start) begin
				mem_addr <= stream_addr;
				remain   <= stream_count;
				armed    <= 1'b1;
			end else if (issue) begin
				// Address wraps at the top of memory
				mem_addr <= mem_addr + 1'b1;
				remain   <= remain - 1'b1;
			end else if (stream_done) begin
				armed <= 1'b0;
			end
			// Matches the memory's two-cycle read latency
			rd_v1 <= issue;
			rd_v2 <= rd_v1;
		end
	end

	assign mem_valid = rd_v2;

	a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		stream_start |-> !armed);

endmodule

//--- fill_frame_assembler.sv
// Frame assembler with XOR checksum and the registered transmit word mux
`timescale 1ns/1ps

module fill_frame_assembler (
	input  logic                        clk,
	input  logic                        arst_n,
	input  fill_pkg::tx_beat_t          beat,
	input  logic [fill_pkg::data_w-1:0] csn,
	input  logic [fill_pkg::data_w-1:0] cc,
	input  logic                        mem_valid,
	input  logic [fill_pkg::data_w-1:0] mem_dout,
	output logic [fill_pkg::data_w-1:0] tx_tdata,
	output logic                        tx_tvalid,
	output logic                        tx_tlast
);

	logic [fill_pkg::data_w-1:0] checksum;

	// New frame starts at CSN, data words fold in as they arrive
	always_ff @(posedge clk) begin
		if (beat.valid && beat.src == fill_pkg::SRC_CSN)
			checksum <= '0;
		else if (mem_valid)
			checksum <= checksum ^ mem_dout;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
		end else begin
			tx_tvalid <= beat.valid || mem_valid;
			// Data words never carry last
			tx_tlast  <= beat.valid && beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_valid) begin
			tx_tdata <= mem_dout;
		end else if (beat.valid) begin
			case (beat.src)
				fill_pkg::SRC_CSN:      tx_tdata <= csn;
				fill_pkg::SRC_CC:       tx_tdata <= cc;
				fill_pkg::SRC_INV_CC:   tx_tdata <= ~cc;
				fill_pkg::SRC_HEADER:   tx_tdata <= beat.word;
				fill_pkg::SRC_CHECKSUM: tx_tdata <= checksum;
				default:                tx_tdata <= beat.word;
			endcase
		end
	end

	// Sequencer waits for stream_done, so the two sources stay apart
	a_no_collision: assert property (@(posedge clk) disable iff (!arst_n)
		!(beat.valid && mem_valid));

endmodule

//--- rd_fill_engine.sv
// Fill-readout engine top level wiring header reader, sequencer, streamer and assembler
`timescale 1ns/1ps

module rd_fill_engine #(
	parameter int addr_w = 12
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        run,
	input  logic [fill_pkg::data_w-1:0] csn,
	input  logic [fill_pkg::data_w-1:0] cc,
	input  logic                        tx_tready,
	input  logic [fill_pkg::data_w-1:0] hdr_fifo_dout,
	input  logic                        hdr_fifo_empty,
	input  logic [fill_pkg::data_w-1:0] mem_dout,
	output logic                        busy,
	output logic                        done,
	output logic [fill_pkg::data_w-1:0] tx_tdata,
	output logic                        tx_tvalid,
	output logic                        tx_tlast,
	output logic                        hdr_fifo_rd_en,
	output logic [addr_w-1:0]           mem_addr
);

	// Reader to sequencer
	logic                   fetch;
	fill_pkg::fill_header_t hdr;
	logic                   hdr_ready;
	logic                   hdr_error;
	// Sequencer to streamer and assembler
	fill_pkg::tx_beat_t     beat;
	logic                   stream_start;
	logic [addr_w-1:0]      stream_addr;
	logic [addr_w-1:0]      stream_count;
	logic                   stream_done;
	logic                   mem_valid;

	fill_header_reader u_reader (
		.clk, .arst_n, .fetch, .hdr_fifo_dout, .hdr_fifo_empty,
		.hdr_fifo_rd_en, .hdr, .hdr_ready, .hdr_error
	);

	fill_sequencer #(.addr_w(addr_w)) u_seq (
		.clk, .arst_n, .run, .tx_tready, .hdr, .hdr_ready, .hdr_error, .stream_done,
		.fetch, .beat, .stream_start, .stream_addr, .stream_count, .busy, .done
	);

	fill_mem_streamer #(.addr_w(addr_w)) u_stream (
		.clk, .arst_n, .stream_start, .stream_addr, .stream_count,
		.mem_addr, .mem_valid, .stream_done
	);

	fill_frame_assembler u_asm (
		.clk, .arst_n, .beat, .csn, .cc, .mem_valid, .mem_dout,
		.tx_tdata, .tx_tvalid, .tx_tlast
	);

endmodule

//--- tb_checks.svh
// LFSR function, compare tasks, frame capture and done wait with timeouts

	int                          errors = 0;
	int                          checks = 0;
	logic [31:0]                 lfsr_state = 32'h362;
	logic [fill_pkg::data_w-1:0] exp_words[$];
	logic [fill_pkg::data_w-1:0] got_words[$];
	logic                        got_lasts[$];
	// tready as the FSM saw it two cycles before each beat
	logic                        got_ready[$];

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits       = {bits[30:0], fb};
		end
		return bits;
	endfunction

	task automatic check_word(input string name, input logic [fill_pkg::data_w-1:0] got,
			input logic [fill_pkg::data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Beats are taken mid-cycle, where the registered outputs are stable
	task automatic capture_frame(input string name);
		int   waited;
		bit   finished;
		logic ready_q;
		waited   = 0;
		finished = 1'b0;
		ready_q  = tx_tready;
		got_words.delete();
		got_lasts.delete();
		got_ready.delete();
		while (!finished && waited < frame_timeout) begin
			@(negedge clk);
			waited++;
			if (tx_tvalid) begin
				got_words.push_back(tx_tdata);
				got_lasts.push_back(tx_tlast);
				got_ready.push_back(ready_q);
				finished = tx_tlast;
			end
			// Still the value driven one negedge back
			ready_q = tx_tready;
		end
		if (!finished) begin
			$display("Timeout in %s, no last beat after %0d cycles", name, waited);
			errors++;
		end else begin
			check_flag("busy", busy, 1'b1);
		end
	endtask

	task automatic wait_done(input string name);
		int waited;
		waited = 0;
		while (!done && waited < done_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (!done) begin
			$display("Timeout in %s, done never pulsed after the last beat", name);
			errors++;
		end
	endtask

	task automatic compare_frame(input string name);
		if (got_words.size() != exp_words.size()) begin
			$display("Frame in %s has %0d words where %0d were expected",
				name, got_words.size(), exp_words.size());
			errors++;
		end
		for (int i = 0; i < got_words.size() && i < exp_words.size(); i++) begin
			check_word($sformatf("tx_tdata[%0d] in %s", i, name), got_words[i], exp_words[i]);
			check_flag($sformatf("tx_tlast[%0d] in %s", i, name), got_lasts[i],
				i == exp_words.size() - 1);
			// Non-data words only go out after the FSM saw tready high
			if (i < lead_words || i == exp_words.size() - 1)
				check_flag($sformatf("tx_tready before word %0d in %s", i, name),
					got_ready[i], 1'b1);
		end
	endtask

//--- tb_rd_fill.sv
// Testbench top with clock, reset, header FIFO and memory models and directed fill tests
`timescale 1ns/1ps

module tb_rd_fill;

	localparam int addr_w        = 12;
	localparam int mem_words     = 1 << addr_w;
	localparam int frame_timeout = 400;
	localparam int done_timeout  = 8;
	// CSN, CC and four header words lead every full frame
	localparam int lead_words    = 6;

	logic                        clk = 1'b0;
	logic                        arst_n;
	logic                        run;
	logic [fill_pkg::data_w-1:0] csn;
	logic [fill_pkg::data_w-1:0] cc;
	logic                        tx_tready;
	logic [fill_pkg::data_w-1:0] hdr_fifo_dout;
	logic                        hdr_fifo_empty;
	logic [fill_pkg::data_w-1:0] mem_dout;
	logic                        busy;
	logic                        done;
	logic [fill_pkg::data_w-1:0] tx_tdata;
	logic                        tx_tvalid;
	logic                        tx_tlast;
	logic                        hdr_fifo_rd_en;
	logic [addr_w-1:0]           mem_addr;

	// Header FIFO contents, head at index 0
	logic [fill_pkg::data_w-1:0] hdr_q[$];
	logic [fill_pkg::data_w-1:0] mem[mem_words];
	logic [fill_pkg::data_w-1:0] mem_p1;
	logic [fill_pkg::data_w-1:0] mem_p2;
	logic                        pop_q;
	logic                        stall;
	int                          hold;

	`include "tb_checks.svh"

	rd_fill_engine #(.addr_w(addr_w)) dut0 (
		.clk, .arst_n, .run, .csn, .cc, .tx_tready, .hdr_fifo_dout, .hdr_fifo_empty,
		.mem_dout, .busy, .done, .tx_tdata, .tx_tvalid, .tx_tlast, .hdr_fifo_rd_en, .mem_addr
	);

	always #50 clk = ~clk;

	// Pop request as the DUT saw it at the edge
	always @(posedge clk) pop_q <= hdr_fifo_rd_en;

	// FWFT FIFO, the popped word is replaced before the next edge
	always @(negedge clk) begin
		if (pop_q && hdr_q.size() > 0)
			void'(hdr_q.pop_front());
		hdr_fifo_empty <= hdr_q.size() == 0;
		hdr_fifo_dout  <= (hdr_q.size() > 0) ? hdr_q[0] : '0;
	end

	// Memory with two cycles of read latency as seen from the DUT
	always @(negedge clk) begin
		mem_dout <= mem_p2;
		mem_p2   <= mem_p1;
		mem_p1   <= mem[mem_addr];
	end

	// Random high and low stretches on tready while stall is set
	always @(negedge clk) begin
		if (!stall) begin
			tx_tready <= 1'b1;
		end else if (hold == 0) begin
			tx_tready <= ~tx_tready;
			hold      <= rand_bits(3);
		end else begin
			hold <= hold - 1;
		end
	end

	// One fill, with a header in the FIFO or with the FIFO left empty
	task automatic run_fill(input string name, input bit with_hdr, input bit bp,
			input logic [addr_w-1:0] start, input logic [addr_w-1:0] size);
		logic [fill_pkg::data_w-1:0] sum;
		logic [fill_pkg::data_w-1:0] trig;
		logic [fill_pkg::data_w-1:0] chan;
		logic [fill_pkg::data_w-1:0] post;
		@(negedge clk);
		sum  = '0;
		csn  = rand_bits(fill_pkg::data_w);
		cc   = rand_bits(fill_pkg::data_w);
		trig = rand_bits(fill_pkg::data_w);
		chan = rand_bits(fill_pkg::data_w);
		post = rand_bits(fill_pkg::data_w);
		exp_words.delete();
		exp_words.push_back(csn);
		if (with_hdr) begin
			hdr_q.push_back(trig);
			hdr_q.push_back(size);
			hdr_q.push_back(chan);
			hdr_q.push_back(post);
			hdr_q.push_back(start);
			exp_words.push_back(cc);
			exp_words.push_back(trig);
			exp_words.push_back(size);
			exp_words.push_back(chan);
			exp_words.push_back(post);
			// Addresses wrap at the top of memory
			for (int i = 0; i < size; i++) begin
				exp_words.push_back(mem[addr_w'(start + i)]);
				sum = sum ^ mem[addr_w'(start + i)];
			end
			exp_words.push_back(sum);
		end else begin
			exp_words.push_back(~cc);
		end
		repeat (2) @(negedge clk);
		stall = bp;
		run   = 1'b1;
		capture_frame(name);
		wait_done(name);
		run   = 1'b0;
		stall = 1'b0;
		compare_frame(name);
	endtask

	// Run low after reset, a waiting header stays untouched
	task automatic test_idle_after_reset();
		repeat (5) hdr_q.push_back(rand_bits(fill_pkg::data_w));
		repeat (10) begin
			@(negedge clk);
			check_flag("tx_tvalid", tx_tvalid, 1'b0);
			check_flag("busy", busy, 1'b0);
			check_flag("hdr_fifo_rd_en", hdr_fifo_rd_en, 1'b0);
		end
		if (hdr_q.size() != 5) begin
			$display("Header FIFO was read while run was low");
			errors++;
		end
		hdr_q.delete();
	endtask

	task automatic test_normal_fill();
		run_fill("normal", 1'b1, 1'b0, 12'h100, 12'd8);
	endtask

	task automatic test_empty_fifo();
		run_fill("empty fifo", 1'b0, 1'b0, 12'h000, 12'd0);
	endtask

	task automatic test_backpressure();
		run_fill("backpressure", 1'b1, 1'b1, 12'h200, 12'd8);
	endtask

	task automatic test_zero_size();
		run_fill("zero size", 1'b1, 1'b0, 12'h300, 12'd0);
	endtask

	task automatic test_addr_wrap();
		run_fill("wrap", 1'b1, 1'b0, 12'hffc, 12'd8);
	endtask

	// Checksum of the second fill must not carry the first one's words
	task automatic test_back_to_back();
		run_fill("first of two", 1'b1, 1'b0, 12'h400, 12'd5);
		run_fill("second of two", 1'b1, 1'b0, 12'h410, 12'd6);
	endtask

	initial begin
		arst_n         = 1'b0;
		run            = 1'b0;
		csn            = '0;
		cc             = '0;
		tx_tready      = 1'b1;
		hdr_fifo_empty = 1'b1;
		hdr_fifo_dout  = '0;
		mem_dout       = '0;
		mem_p1         = '0;
		mem_p2         = '0;
		pop_q          = 1'b0;
		stall          = 1'b0;
		hold           = 0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = rand_bits(fill_pkg::data_w);
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		test_idle_after_reset();
		test_normal_fill();
		test_empty_fifo();
		test_backpressure();
		test_zero_size();
		test_addr_wrap();
		test_back_to_back();
		repeat (4) @(negedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
fill_pkg.sv
fill_header_reader.sv
fill_sequencer.sv
fill_mem_streamer.sv
fill_frame_assembler.sv
rd_fill_engine.sv
tb_rd_fill.sv

//--- Bender.yml
package:
  name: rd_fill_engine

sources:
  - files:
      - fill_pkg.sv
      - fill_header_reader.sv
      - fill_sequencer.sv
      - fill_mem_streamer.sv
      - fill_frame_assembler.sv
      - rd_fill_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rd_fill.sv
